/* hdl/keyIvLoader.sv */
`timescale 1ns/1ns
`include "triviumKs_cfg.svh"

module keyIvLoader (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  logic                     EN,
    input  logic                     EncDec,
    input  logic                     Krdy,
    input  logic                     Drdy,
    input  logic [`TRIV_KEY_BITS-1:0] Kin,
    input  logic [`TRIV_IV_BITS-1:0]  Din,
    input  logic                     busy,
    output logic                     Kvld,
    output triviumPkg::loadReq_t     loadReq
);

    // IV lands at the low end of register B
    localparam int ivBase = 93;

    logic                      canAccept;
    logic                      keyAccept;
    logic                      ivAccept;
    logic [`TRIV_KEY_BITS-1:0] keyReg;
    logic [`TRIV_IV_BITS-1:0]  ivRev;
    triviumPkg::stateWord_t    initState;

    // Only accepted requests ever leave this block
    assign canAccept = EN && !EncDec && !busy;
    assign keyAccept = canAccept && Krdy;
    assign ivAccept  = canAccept && Drdy && !Krdy;  // Key load wins

    // Lowest input byte becomes the top byte of the field
    assign ivRev = {<<8{Din}};

    always_ff @(posedge CLK) begin
        if (keyAccept) begin
            keyReg <= {<<8{Kin}};
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            Kvld <= 1'b0;
        end else begin
            Kvld <= keyAccept;
        end
    end

    // Initial state through the flat view
    always_comb begin
        initState.bits = '0;
        initState.bits[`TRIV_STATE_BITS-1 -: 3] = 3'b111;  // Top of register C
        initState.bits[`TRIV_KEY_BITS-1:0] = keyReg;       // Register A
        initState.bits[ivBase +: `TRIV_IV_BITS] = ivRev;
    end

    always_comb begin
        loadReq.start = ivAccept;
        loadReq.state = initState;
    end

    // Krdy is a strobe, so an acknowledge never repeats
    assert property (@(posedge CLK) disable iff (!RSTn) Kvld |=> !Kvld)
        else $error("Kvld held for more than one cycle");

endmodule

/* hdl/keystreamCollector.sv */
`timescale 1ns/1ns
`include "triviumKs_cfg.svh"

module keystreamCollector (
    input  logic                      CLK,
    input  logic                      RSTn,
    input  triviumPkg::ksBeat_t       beat,
    output logic [`TRIV_OUT_BITS-1:0] Dout,
    output logic                      Dvld
);

    localparam int roundsPerClk   = `TRIV_BITS_PER_CLK;
    localparam int beatsPerBlock  = `TRIV_OUT_BITS / roundsPerClk;
    localparam int beatCntWidth   = $clog2(beatsPerBlock + 1);

    logic [`TRIV_OUT_BITS-1:0] assembly;
    logic [beatCntWidth-1:0]   beatCnt;

    // New bits enter low, first keystream bit ends at the top
    always_ff @(posedge CLK) begin
        if (beat.valid) begin
            assembly <= {assembly[`TRIV_OUT_BITS-1-roundsPerClk:0], beat.bits};
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            Dout    <= '0;
            Dvld    <= 1'b0;
            beatCnt <= '0;
        end else begin
            Dvld <= beat.done;  // Single cycle pulse
            if (beat.done) begin
                Dout    <= assembly;  // Held until the next block
                beatCnt <= '0;
            end else if (beat.valid) begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    // Engine phase boundary and block size must agree
    assert property (@(posedge CLK) disable iff (!RSTn)
        beat.done |-> (beatCnt == beatCntWidth'(beatsPerBlock)))
        else $error("Block done after %0d beats", beatCnt);

endmodule

/* hdl/keystreamEngine.sv */
`timescale 1ns/1ns
`include "triviumKs_cfg.svh"

module keystreamEngine (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 EN,
    input  triviumPkg::loadReq_t loadReq,
    output logic                 busy,
    output triviumPkg::ksBeat_t  beat
);

    localparam int roundsPerClk = `TRIV_BITS_PER_CLK;
    localparam int totalRounds  = `TRIV_WARMUP + `TRIV_OUT_BITS;
    localparam int cntWidth     = $clog2(totalRounds + 1);

    localparam logic [cntWidth-1:0] cntStep   = cntWidth'(roundsPerClk);
    localparam logic [cntWidth-1:0] cntWarmup = cntWidth'(`TRIV_WARMUP);
    localparam logic [cntWidth-1:0] cntTotal  = cntWidth'(totalRounds);

    // Block boundaries must fall on whole clocks
    if ((`TRIV_WARMUP % roundsPerClk) != 0 || (`TRIV_OUT_BITS % roundsPerClk) != 0) begin : g_badCfg
        $error("TRIV_BITS_PER_CLK must divide warm-up and output sizes");
    end

    triviumPkg::stateWord_t   state;
    triviumPkg::stateWord_t   chain [0:roundsPerClk];
    logic [roundsPerClk-1:0]  ksBits;
    logic [cntWidth-1:0]      roundCnt;
    logic                     outPhase;
    logic                     runEnd;
    logic                     advance;

    // Round chain, one instance per round this clock
    assign chain[0] = state;

    for (genvar i = 0; i < roundsPerClk; i++) begin : g_round
        triviumRound u_round (
            .stateIn  (chain[i]),
            .ksBit    (ksBits[roundsPerClk-1-i]),  // Earliest round at MSB
            .stateOut (chain[i+1])
        );
    end

    assign outPhase = (roundCnt >= cntWarmup);
    assign runEnd   = (roundCnt == cntTotal);
    assign advance  = busy && EN && !runEnd;

    // Control, EN low holds everything
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            busy     <= 1'b0;
            roundCnt <= '0;
        end else if (loadReq.start) begin
            busy     <= 1'b1;
            roundCnt <= '0;
        end else if (busy && EN) begin
            if (runEnd) begin
                busy     <= 1'b0;  // Released by done
                roundCnt <= '0;
            end else begin
                roundCnt <= roundCnt + cntStep;
            end
        end
    end

    // Cipher state
    always_ff @(posedge CLK) begin
        if (loadReq.start) begin
            state <= loadReq.state;
        end else if (advance) begin
            state <= chain[roundsPerClk];
        end
    end

    always_comb begin
        beat.valid = advance && outPhase;
        beat.done  = busy && EN && runEnd;  // Cycle after the last output round
        beat.bits  = ksBits;
    end

    // Loader gates on busy, a restart mid-run would be lost
    assert property (@(posedge CLK) disable iff (!RSTn) loadReq.start |-> !busy)
        else $error("Load request while engine busy");

    assert property (@(posedge CLK) disable iff (!RSTn) !(beat.valid && beat.done))
        else $error("Keystream beat valid together with done");

endmodule

/* hdl/triviumComp.sv */
`timescale 1ns/1ns
`include "triviumKs_cfg.svh"

module triviumComp (
    input  logic [`TRIV_KEY_BITS-1:0] Kin,   // Key input
    input  logic [`TRIV_IV_BITS-1:0]  Din,   // IV input
    output logic [`TRIV_OUT_BITS-1:0] Dout,  // Keystream block
    input  logic                      Krdy,
    input  logic                      Drdy,
    input  logic                      EncDec,  // Requests ignored when high
    input  logic                      RSTn,
    input  logic                      EN,      // Freezes the core when low
    input  logic                      CLK,
    output logic                      BSY,
    output logic                      Kvld,
    output logic                      Dvld
);

    triviumPkg::loadReq_t loadReq;
    triviumPkg::ksBeat_t  beat;
    logic                 busy;

    keyIvLoader u_loader (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .EN      (EN),
        .EncDec  (EncDec),
        .Krdy    (Krdy),
        .Drdy    (Drdy),
        .Kin     (Kin),
        .Din     (Din),
        .busy    (busy),
        .Kvld    (Kvld),
        .loadReq (loadReq)
    );

    keystreamEngine u_engine (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .EN      (EN),
        .loadReq (loadReq),
        .busy    (busy),
        .beat    (beat)
    );

    keystreamCollector u_collector (
        .CLK  (CLK),
        .RSTn (RSTn),
        .beat (beat),
        .Dout (Dout),
        .Dvld (Dvld)
    );

    assign BSY = busy;

endmodule

/* hdl/triviumPkg.sv */
`include "triviumKs_cfg.svh"

package triviumPkg;

    // Register view of the state, MSB first
    typedef struct packed {
        logic [110:0] regC;  // State bits 287..177
        logic [83:0]  regB;  // State bits 176..93
        logic [92:0]  regA;  // State bits 92..0
    } triviumRegs_t;

    // Flat word for loading and shifting, registers for the round taps
    typedef union packed {
        logic [`TRIV_STATE_BITS-1:0] bits;
        triviumRegs_t                regs;
    } stateWord_t;

    // Loader to engine
    typedef struct packed {
        logic       start;  // One cycle, request already accepted
        stateWord_t state;  // Initial state for the run
    } loadReq_t;

    // Engine to collector
    typedef struct packed {
        logic                          valid;  // Output phase round bits
        logic                          done;   // Run finished
        logic [`TRIV_BITS_PER_CLK-1:0] bits;   // Earliest round in MSB
    } ksBeat_t;

endpackage

/* hdl/triviumRound.sv */
`timescale 1ns/1ns

module triviumRound (
    input  triviumPkg::stateWord_t stateIn,
    output logic                   ksBit,
    output triviumPkg::stateWord_t stateOut
);

    logic [110:0] regC;
    logic [83:0]  regB;
    logic [92:0]  regA;
    logic         t1;
    logic         t2;
    logic         t3;
    logic         fbA;  // Feeds register B
    logic         fbB;  // Feeds register C
    logic         fbC;  // Feeds register A

    assign regA = stateIn.regs.regA;
    assign regB = stateIn.regs.regB;
    assign regC = stateIn.regs.regC;

    // Linear tap sums
    assign t1 = regA[65] ^ regA[92];
    assign t2 = regB[68] ^ regB[83];
    assign t3 = regC[65] ^ regC[110];

    assign ksBit = t1 ^ t2 ^ t3;

    // Nonlinear feedback, each into the next register
    assign fbA = t1 ^ (regA[90] & regA[91]) ^ regB[77];
    assign fbB = t2 ^ (regB[81] & regB[82]) ^ regC[86];
    assign fbC = t3 ^ (regC[108] & regC[109]) ^ regA[68];

    // Every register moves up one place, new bit at its low end
    always_comb begin
        stateOut.regs.regA = {regA[91:0], fbC};
        stateOut.regs.regB = {regB[82:0], fbA};
        stateOut.regs.regC = {regC[109:0], fbB};
    end

endmodule

/* include/triviumKs_cfg.svh */
`ifndef TRIVIUMKS_CFG_SVH
`define TRIVIUMKS_CFG_SVH

// Cipher input widths
`define TRIV_KEY_BITS   80
`define TRIV_IV_BITS    80

// Full internal state, registers A, B and C together
`define TRIV_STATE_BITS 288

// Rounds discarded before keystream is taken
`define TRIV_WARMUP     1152

// Keystream bits per output block
`define TRIV_OUT_BITS   128

// Rounds per clock, one of 1, 2, 4, 8, 16, 32
`define TRIV_BITS_PER_CLK 1

`endif

/* run.sh */
#!/bin/sh
# Builds the Trivium testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f triviumKs.f --top-module triviumCompTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VtriviumCompTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* test/triviumCompTb.sv */
`timescale 1ns/1ns
`include "triviumKs_cfg.svh"

module triviumCompTb;

    localparam int maxRecords   = 64;
    localparam int fieldsPerRec = 5;
    localparam int runCycles    = (`TRIV_WARMUP + `TRIV_OUT_BITS) / `TRIV_BITS_PER_CLK;
    localparam int stallWindow  = runCycles * 3 / 4;  // All EN stalls land before this
    localparam int kvldLatency  = 1;

    logic                      CLK;
    logic                      RSTn;
    logic [`TRIV_KEY_BITS-1:0] Kin;
    logic [`TRIV_IV_BITS-1:0]  Din;
    logic [`TRIV_OUT_BITS-1:0] Dout;
    logic                      Krdy;
    logic                      Drdy;
    logic                      EncDec;
    logic                      EN;
    logic                      BSY;
    logic                      Kvld;
    logic                      Dvld;

    logic [79:0]               stim [0:maxRecords*fieldsPerRec-1];
    logic [79:0]               curKey;
    logic [`TRIV_OUT_BITS-1:0] lastDout;
    logic                      lastDvld;
    logic                      monitorOn = 1'b0;
    int                        errorCount = 0;
    int                        cycleCnt = 0;
    int                        cycleLimit = 0;

    triviumComp u_dut (
        .Kin    (Kin),
        .Din    (Din),
        .Dout   (Dout),
        .Krdy   (Krdy),
        .Drdy   (Drdy),
        .EncDec (EncDec),
        .RSTn   (RSTn),
        .EN     (EN),
        .CLK    (CLK),
        .BSY    (BSY),
        .Kvld   (Kvld),
        .Dvld   (Dvld)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic reportError(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        errorCount++;
    endtask

    // Bit-serial cipher, state s1..s288 as in the cipher description
    function automatic logic [`TRIV_OUT_BITS-1:0] modelBlock(
        input logic [79:0] key,
        input logic [79:0] iv
    );
        logic [288:1]              s;
        logic [79:0]               keyField;
        logic [79:0]               ivField;
        logic [`TRIV_OUT_BITS-1:0] blk;
        logic                      t1;
        logic                      t2;
        logic                      t3;
        logic                      z;
        for (int i = 0; i < 10; i++) begin
            keyField[8*(9-i) +: 8] = key[8*i +: 8];  // Byte order swapped
            ivField[8*(9-i) +: 8]  = iv[8*i +: 8];
        end
        s = '0;
        s[80:1] = keyField;
        s[173:94] = ivField;
        s[288:286] = 3'b111;
        blk = '0;
        for (int r = 0; r < `TRIV_WARMUP + `TRIV_OUT_BITS; r++) begin
            t1 = s[66] ^ s[93];
            t2 = s[162] ^ s[177];
            t3 = s[243] ^ s[288];
            z = t1 ^ t2 ^ t3;
            t1 = t1 ^ (s[91] & s[92]) ^ s[171];
            t2 = t2 ^ (s[175] & s[176]) ^ s[264];
            t3 = t3 ^ (s[286] & s[287]) ^ s[69];
            s[93:1] = {s[92:1], t3};
            s[177:94] = {s[176:94], t1};
            s[288:178] = {s[287:178], t2};
            if (r >= `TRIV_WARMUP) begin
                blk = {blk[`TRIV_OUT_BITS-2:0], z};  // First bit ends at the top
            end
        end
        return blk;
    endfunction

    function automatic logic [79:0] randomWord();
        logic [95:0] w;
        w = {$urandom, $urandom, $urandom};
        return w[79:0];
    endfunction

    task automatic loadKey(input logic [79:0] key, input int expLatency);
        int lat;
        @(posedge CLK);
        Kin  <= key;
        Krdy <= 1'b1;
        @(posedge CLK);
        Krdy <= 1'b0;  // Sampling edge
        lat = 1;
        @(negedge CLK);
        while (!Kvld && lat < 4) begin
            @(negedge CLK);
            lat++;
        end
        if (!Kvld) begin
            reportError("Kvld never raised after Krdy");
        end else if (lat != expLatency) begin
            reportError($sformatf("Kvld after %0d cycles, expected %0d", lat, expLatency));
        end
        @(negedge CLK);
        if (Kvld) begin
            reportError("Kvld high for more than one cycle");
        end
        curKey = key;
    endtask

    // Krdy and Drdy with EncDec high
    task automatic ignoreEncDec(input logic [79:0] decoyKey, input logic [79:0] iv);
        for (int k = 0; k < 4; k++) begin
            @(posedge CLK);
            case (k)
                0: begin
                    EncDec <= 1'b1;
                    Kin    <= decoyKey;
                    Krdy   <= 1'b1;
                end
                1: begin
                    Krdy <= 1'b0;
                    Din  <= iv;
                    Drdy <= 1'b1;
                end
                2: Drdy <= 1'b0;
                default: EncDec <= 1'b0;
            endcase
            @(negedge CLK);
            if (Kvld) begin
                reportError("Kvld raised with EncDec high");
            end
            if (BSY) begin
                reportError("Run started with EncDec high");
            end
        end
    endtask

    task automatic runBlock(
        input logic [79:0] iv,
        input int          stallCnt,
        input int          expLatency,
        input logic        pokeBusy,
        input logic [79:0] decoyKey
    );
        logic [`TRIV_OUT_BITS-1:0] expected;
        int                        lat;
        int                        remaining;
        expected = modelBlock(curKey, iv);
        @(posedge CLK);
        Din  <= iv;
        Drdy <= 1'b1;
        @(posedge CLK);
        Drdy <= 1'b0;  // Sampling edge
        @(negedge CLK);
        if (!BSY) begin
            reportError("BSY not raised after Drdy");
        end
        lat = 0;
        remaining = stallCnt;
        while (!Dvld) begin
            @(posedge CLK);
            lat++;
            if (remaining > 0 && lat < stallWindow &&
                (($urandom % 4) == 0 || remaining >= stallWindow - lat)) begin
                EN <= 1'b0;
                remaining--;
            end else begin
                EN <= 1'b1;
            end
            if (pokeBusy) begin
                case (lat)
                    3: begin
                        Kin  <= decoyKey;
                        Krdy <= 1'b1;
                    end
                    4: begin
                        Krdy <= 1'b0;
                        Drdy <= 1'b1;
                    end
                    5: Drdy <= 1'b0;
                    default: ;
                endcase
            end
            @(negedge CLK);
            if (Kvld) begin
                reportError("Kvld raised during a run");
            end
        end
        if (lat != expLatency) begin
            reportError($sformatf("Dvld after %0d cycles, expected %0d", lat, expLatency));
        end
        if (BSY) begin
            reportError("BSY still high with Dvld");
        end
        if (Dout !== expected) begin
            reportError($sformatf("Dout %h, expected %h", Dout, expected));
        end
    endtask

    // Dout only moves with Dvld, and Dvld is a single pulse
    always @(negedge CLK) begin
        if (monitorOn) begin
            if (Dvld && lastDvld) begin
                reportError("Dvld high for two cycles");
            end
            if (Dout !== lastDout && !Dvld) begin
                reportError("Dout changed without Dvld");
            end
        end
        lastDvld <= Dvld;
        lastDout <= Dout;
    end

    initial begin : watchdog
        wait (cycleLimit > 0);
        while (cycleCnt < cycleLimit) begin
            @(posedge CLK);
        end
        $display("Run timed out after %0d cycles", cycleCnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : mainSeq
        int    numRecs;
        int    base;
        int    op;
        int    stallCnt;
        int    expLat;
        int    errsBefore;
        int    testsRun;
        int    testsFailed;
        string name;
        void'($urandom(32'hb235_f8cd));
        RSTn   <= 1'b0;
        Kin    <= '0;
        Din    <= '0;
        Krdy   <= 1'b0;
        Drdy   <= 1'b0;
        EncDec <= 1'b0;
        EN     <= 1'b1;
        testsRun = 0;
        testsFailed = 0;
        $readmemh("test/triviumStimulus.txt", stim);
        numRecs = 0;
        while (numRecs < maxRecords && stim[numRecs*fieldsPerRec] != 80'h0) begin
            numRecs++;
        end
        cycleLimit = (numRecs + 1) * (runCycles + 50) + 200;
        repeat (4) @(posedge CLK);
        RSTn <= 1'b1;

        @(negedge CLK);
        errsBefore = errorCount;
        if (BSY || Kvld || Dvld || Dout !== '0) begin
            reportError("Outputs not cleared by reset");
        end
        monitorOn = 1'b1;
        testsRun++;
        if (errorCount != errsBefore) begin
            testsFailed++;
        end
        $display("Test 0 reset state %s", (errorCount == errsBefore) ? "passed" : "failed");

        if (numRecs == 0) begin
            $display("No stimulus records could be read");
            errorCount++;
        end

        for (int t = 0; t < numRecs; t++) begin
            base = t * fieldsPerRec;
            op = int'(stim[base][3:0]);
            stallCnt = int'(stim[base+3][15:0]);
            expLat = int'(stim[base+4][15:0]);
            errsBefore = errorCount;
            case (op)
                1: begin
                    name = "key load";
                    loadKey(stim[base+1], expLat);
                end
                2: begin
                    name = "file run";
                    runBlock(stim[base+2], stallCnt, expLat, 1'b0, '0);
                end
                3: begin
                    name = "random run";
                    loadKey(randomWord(), kvldLatency);
                    runBlock(randomWord(), stallCnt, expLat, 1'b0, '0);
                end
                4: begin
                    name = "ignored requests";
                    ignoreEncDec(stim[base+1], stim[base+2]);
                    runBlock(stim[base+2], stallCnt, expLat, 1'b1, stim[base+1]);
                end
                default: begin
                    name = "unknown";
                    $display("Unknown opcode %0d in stimulus record %0d", op, t + 1);
                    errorCount++;
                end
            endcase
            testsRun++;
            if (errorCount != errsBefore) begin
                testsFailed++;
            end
            $display("Test %0d %s %s", t + 1, name,
                     (errorCount == errsBefore) ? "passed" : "failed");
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/triviumStimulus.txt */
// Columns in hex: op key iv stall expectedLatency, one test per line
// op 1 key load, 2 run, 3 random key and IV run, 4 ignored requests (key = decoy), 0 end
1 00000000000000000000 0 0 1
2 0 00000000000000000000 0 501
2 0 0123456789abcdef0123 0 501
1 80000000000000000000 0 0 1
2 0 00000000000000000000 0 501
2 0 ffffffffffffffffffff c 50d
1 0f62b5085bae0154a7fa 0 0 1
2 0 288ff65dc42b92f960c7 25 526
3 0 0 0 501
3 0 0 7 508
3 0 0 1f 520
1 ffeeddccbbaa99887766 0 0 1
4 1234567890abcdef1234 0badc0ffee0123456789 0 501
2 0 5555aaaa5555aaaa5555 10 511
0 0 0 0 0

/* triviumKs.f */
+incdir+include
hdl/triviumPkg.sv
hdl/triviumRound.sv
hdl/keyIvLoader.sv
hdl/keystreamEngine.sv
hdl/keystreamCollector.sv
hdl/triviumComp.sv
test/triviumCompTb.sv
